// File: list.f
+incdir+source
source/ctaFrontEndPkg.sv
source/ctaController.sv
source/threadController.sv
source/warpScheduler.sv
source/ctaFrontEnd.sv
testbench/tbCtaFrontEnd.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f --top-module tbCtaFrontEnd \
	--Mdir obj_dir -o simTb

./obj_dir/simTb > sim.log
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: testbench/tbCtaFrontEnd.sv
// runs one 3x2x1 grid on four slots with all lanes enabled; cfg_i is fixed before reset is released
`timescale 1ns/1ps
`include "ctaFrontEnd_params.svh"

module tbCtaFrontEnd;
	import ctaFrontEndPkg::*;

	localparam int MAX_CYCLES = 400; // about four times the summed test lengths

	logic clk;
	logic reset_i;
	logic stall_i;
	gridCfgT cfg_i;
	exitReqT exitReq_i;
	dispatchT dispatch_o;
	issueT issue_o;
	logic kernelDone_o;
	logic kernelStall_o;

	// reference model state
	ctaStateT mState;
	logic [`NUM_WARP-1:0] mRun;
	logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] mExited;
	logic [`NUM_WARP_LOG-1:0] mLast; // last issued warp
	logic [`NUM_WARP_LOG-1:0] mFillSlot;
	ctaIdT mNextId;
	int mDispCnt;
	logic mExitPend;
	logic [`NUM_WARP_LOG-1:0] mExitWarp;
	issueT expIssue;
	dispatchT expDisp;

	string testName;
	int testNum;
	int errCount;
	int errAtStart;
	int checkCount;
	int cycles;
	int issueCount;
	int dispCount;
	logic [`NUM_WARP_LOG-1:0] lastIssueWarp;
	logic [`NUM_WARP_LOG-1:0] dispSlotLog [0:7];
	ctaIdT dispIdLog [0:7];
	integer seed;
	logic [`SIZE_CORE-1:0] partialMask;

	ctaFrontEnd u_dut (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_i),
		.cfg_i(cfg_i),
		.exitReq_i(exitReq_i),
		.dispatch_o(dispatch_o),
		.issue_o(issue_o),
		.kernelDone_o(kernelDone_o),
		.kernelStall_o(kernelStall_o)
	);

	always #20 clk = ~clk;

	// linear CTA order, x wraps first, then y, then z
	function automatic ctaIdT nextCtaId(input ctaIdT id, input gridCfgT c);
		ctaIdT n;
		n = id;
		n.x = id.x + 1'b1;
		if (n.x == c.nctaX) begin
			n.x = '0;
			n.y = id.y + 1'b1;
			if (n.y == c.nctaY) begin
				n.y = '0;
				n.z = id.z + 1'b1;
			end
		end
		return n;
	endfunction

	function automatic logic [`SIZE_CORE-1:0] expectedMask(
		input logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] exited,
		input logic [`SIZE_CORE-1:0] enMask,
		input logic [`NUM_WARP_LOG-1:0] w);
		return enMask & ~exited[w]; // enabled lanes still alive
	endfunction

	function automatic logic [`NUM_WARP_LOG-1:0] pickWarp(input logic [`NUM_WARP-1:0] run,
		input logic [`NUM_WARP_LOG-1:0] last);
		logic [`NUM_WARP_LOG-1:0] c;
		for (int i = 1; i <= `NUM_WARP; i++) begin
			c = last + i[`NUM_WARP_LOG-1:0];
			if (run[c]) begin
				return c;
			end
		end
		return last;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checkCount++;
		if (expVal !== actVal) begin
			errCount++;
			$display("ERR %s expected %h actual %h", name, expVal, actVal);
		end
	endtask

	task automatic startTest(input string name);
		testNum++;
		testName = name;
		errAtStart = errCount;
	endtask

	task automatic finishTest();
		$display("test %0d %s: %s, %0d errors", testNum, testName,
			(errCount == errAtStart) ? "ok" : "mismatch", errCount - errAtStart);
	endtask

	// request held for one cycle, returns on the edge the DUT samples it
	task automatic sendExit(input logic [`NUM_WARP_LOG-1:0] w, input logic [`SIZE_CORE-1:0] m);
		@(posedge clk);
		exitReq_i <= {1'b1, w, m};
		@(posedge clk);
		exitReq_i <= '0;
	endtask

	// cycle model of fill, refill, exit tracking and round-robin issue
	always @(posedge clk) begin
		ctaIdT nId;
		logic [`NUM_WARP-1:0] nRun;
		logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] nExited;
		logic [`SIZE_CORE-1:0] merged;
		issueT nIssue;
		dispatchT nDisp;
		int total;
		total = int'(cfg_i.nctaX) * int'(cfg_i.nctaY) * int'(cfg_i.nctaZ);
		if (reset_i) begin
			mState <= FILL;
			mRun <= '0;
			mExited <= '0;
			mLast <= '1;
			mFillSlot <= '0;
			mNextId <= '0;
			mDispCnt <= 0;
			mExitPend <= 1'b0;
			expIssue <= '0;
			expDisp <= '0;
		end else if (stall_i) begin
			expIssue <= '0; // everything frozen
			expDisp <= '0;
		end else begin
			nIssue = '0;
			nDisp = '0;
			nRun = mRun;
			nExited = mExited;
			nId = mNextId;
			if (mRun != '0) begin
				nIssue.valid = 1'b1;
				nIssue.warp = pickWarp(mRun, mLast);
				nIssue.mask = expectedMask(mExited, cfg_i.simdEnMask, nIssue.warp);
				mLast <= nIssue.warp;
			end
			if (mState == FILL) begin
				if (mDispCnt < total) begin
					nDisp = {1'b1, mFillSlot, mNextId};
					nRun[mFillSlot] = 1'b1;
					nId = nextCtaId(mNextId, cfg_i);
				end
				if (mDispCnt + 1 >= total || mFillSlot == cfg_i.nctaSM) begin
					mState <= RUN;
				end else begin
					mFillSlot <= mFillSlot + 1'b1;
				end
			end else if (mExitPend) begin
				if (mDispCnt < total) begin
					nDisp = {1'b1, mExitWarp, mNextId}; // same slot, next CTA
					nId = nextCtaId(mNextId, cfg_i);
				end else begin
					nRun[mExitWarp] = 1'b0;
				end
			end
			if (mState == RUN && mDispCnt == total && mRun == '0) begin
				mState <= DONE; // every CTA handed out and every slot retired
			end
			mExitPend <= 1'b0;
			if (exitReq_i.valid) begin
				merged = mExited[exitReq_i.warp] | exitReq_i.mask;
				if ((merged & cfg_i.simdEnMask) == cfg_i.simdEnMask) begin
					nExited[exitReq_i.warp] = '0;
					mExitPend <= 1'b1;
					mExitWarp <= exitReq_i.warp;
				end else begin
					nExited[exitReq_i.warp] = merged;
				end
			end
			if (nDisp.valid) begin
				mDispCnt <= mDispCnt + 1;
			end
			mRun <= nRun;
			mExited <= nExited;
			mNextId <= nId;
			expIssue <= nIssue;
			expDisp <= nDisp;
		end
	end

	// outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (!reset_i) begin
			checkValue({testName, " issue valid"}, 32'(expIssue.valid), 32'(issue_o.valid));
			if (expIssue.valid && issue_o.valid) begin
				checkValue({testName, " issue warp"}, 32'(expIssue.warp), 32'(issue_o.warp));
				checkValue({testName, " issue mask"}, 32'(expIssue.mask), 32'(issue_o.mask));
			end
			if (issue_o.valid) begin
				issueCount++;
				lastIssueWarp = issue_o.warp;
			end
			checkValue({testName, " dispatch valid"}, 32'(expDisp.valid), 32'(dispatch_o.valid));
			if (expDisp.valid && dispatch_o.valid) begin
				checkValue({testName, " dispatch warp"}, 32'(expDisp.warp), 32'(dispatch_o.warp));
				checkValue({testName, " dispatch id"}, 32'(expDisp.ctaId), 32'(dispatch_o.ctaId));
			end
			checkValue({testName, " kernel done"}, 32'(mState == DONE), 32'(kernelDone_o));
			checkValue({testName, " kernel stall"}, 32'(mRun == '0), 32'(kernelStall_o));
			if (dispatch_o.valid) begin
				if (dispCount < 8) begin
					dispSlotLog[dispCount] = dispatch_o.warp;
					dispIdLog[dispCount] = dispatch_o.ctaId;
				end
				dispCount++;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		int d0;
		int i0;
		logic [`NUM_WARP_LOG-1:0] held;
		logic [`NUM_WARP_LOG-1:0] doneSeq [0:3];
		clk = 1'b0;
		reset_i = 1'b1;
		stall_i = 1'b0;
		exitReq_i = '0;
		cfg_i.nctaX = 8'd3;
		cfg_i.nctaY = 8'd2;
		cfg_i.nctaZ = 8'd1;
		cfg_i.nctaSM = 2'd3;
		cfg_i.simdEnMask = 8'hFF;
		seed = 25;
		cycles = 0;
		testName = "reset";
		doneSeq = '{2'd2, 2'd3, 2'd1, 2'd0};
		repeat (5) @(posedge clk);
		reset_i <= 1'b0;

		startTest("fill");
		while (dispCount < 4) @(posedge clk);
		for (int k = 0; k < 4; k++) begin
			checkValue("fill slot", k, 32'(dispSlotLog[k]));
		end
		checkValue("fill id 0", 24'h000000, 32'(dispIdLog[0]));
		checkValue("fill id 1", 24'h010000, 32'(dispIdLog[1]));
		checkValue("fill id 2", 24'h020000, 32'(dispIdLog[2]));
		checkValue("fill id 3", 24'h000100, 32'(dispIdLog[3]));
		finishTest();

		startTest("round robin");
		i0 = issueCount;
		repeat (8) @(posedge clk);
		checkValue("round robin count", i0 + 8, issueCount); // one issue per cycle
		finishTest();

		startTest("partial exit");
		partialMask = ($random(seed) & 8'h7F) | 8'h01; // never the whole warp
		d0 = dispCount;
		sendExit(2'd1, partialMask);
		@(posedge clk);
		@(negedge clk);
		while (!(issue_o.valid && issue_o.warp == 2'd1)) @(negedge clk);
		checkValue("partial exit mask", 32'(8'hFF & ~partialMask), 32'(issue_o.mask));
		repeat (4) @(posedge clk);
		checkValue("partial exit no dispatch", d0, dispCount);
		finishTest();

		startTest("complete exit");
		sendExit(2'd1, ~partialMask);
		@(posedge clk);
		@(negedge clk);
		checkValue("complete valid", 1, 32'(dispatch_o.valid));
		checkValue("complete slot", 1, 32'(dispatch_o.warp));
		checkValue("complete id", 24'h010100, 32'(dispatch_o.ctaId)); // fifth CTA is (1,1,0)
		finishTest();

		startTest("stall");
		sendExit(2'd0, 8'hFF); // slot 0 refill falls due as the stall begins
		stall_i <= 1'b1;
		@(posedge clk);
		held = lastIssueWarp;
		i0 = issueCount;
		d0 = dispCount;
		repeat (4) @(posedge clk);
		stall_i <= 1'b0;
		@(posedge clk);
		checkValue("stall issues", i0, issueCount);
		checkValue("stall dispatches", d0, dispCount);
		@(negedge clk);
		checkValue("stall resume valid", 1, 32'(issue_o.valid));
		checkValue("stall resume warp", 32'(pickWarp(mRun, held)), 32'(issue_o.warp));
		checkValue("stall refill valid", 1, 32'(dispatch_o.valid));
		finishTest();

		startTest("kernel done");
		for (int k = 0; k < 4; k++) begin
			sendExit(doneSeq[k], 8'hFF);
			repeat (3) @(posedge clk);
		end
		@(negedge clk);
		while (!kernelDone_o) @(negedge clk);
		checkValue("done stall", 1, 32'(kernelStall_o));
		repeat (4) begin
			@(negedge clk);
			checkValue("done no issue", 0, 32'(issue_o.valid));
			checkValue("done held", 1, 32'(kernelDone_o));
		end
		@(posedge clk);
		checkValue("done dispatch total", 6, dispCount);
		finishTest();

		$display("tests %0d, checks %0d, errors %0d", testNum, checkCount, errCount);
		if (errCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end
endmodule

// File: source/ctaFrontEnd.sv
// cfg_i must stay stable from reset on; stall_i freezes dispatch, exit tracking and issue alike
`timescale 1ns/1ps
`include "ctaFrontEnd_params.svh"

module ctaFrontEnd (
	input logic clk,
	input logic reset_i,
	input logic stall_i,
	input ctaFrontEndPkg::gridCfgT cfg_i,
	input ctaFrontEndPkg::exitReqT exitReq_i,
	output ctaFrontEndPkg::dispatchT dispatch_o,
	output ctaFrontEndPkg::issueT issue_o,
	output logic kernelDone_o,
	output logic kernelStall_o
);

	logic [`NUM_WARP-1:0] runMask; // slots holding a live CTA
	logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] exitedLanes;
	logic ctaExit;
	logic [`NUM_WARP_LOG-1:0] exitWarp;

	// hands CTA ids to slots and tracks kernel completion
	ctaController u_ctaCtrl (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_i),
		.cfg_i(cfg_i),
		.ctaExit_i(ctaExit),
		.exitWarp_i(exitWarp),
		.runMask_o(runMask),
		.dispatch_o(dispatch_o),
		.kernelDone_o(kernelDone_o),
		.kernelStall_o(kernelStall_o)
	);

	threadController u_threadCtrl (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_i),
		.simdEnMask_i(cfg_i.simdEnMask),
		.exitReq_i(exitReq_i),
		.exitedLanes_o(exitedLanes),
		.ctaExit_o(ctaExit), // one pulse per finished CTA
		.exitWarp_o(exitWarp)
	);

	warpScheduler u_warpSched (
		.clk(clk),
		.reset_i(reset_i),
		.stall_i(stall_i),
		.simdEnMask_i(cfg_i.simdEnMask),
		.runMask_i(runMask),
		.exitedLanes_i(exitedLanes),
		.issue_o(issue_o)
	);
endmodule

// File: source/warpScheduler.sv
// one issue per unstalled cycle; the first warp issued after reset is the lowest running slot
`timescale 1ns/1ps
`include "ctaFrontEnd_params.svh"

module warpScheduler (
	input logic clk,
	input logic reset_i,
	input logic stall_i,
	input logic [`SIZE_CORE-1:0] simdEnMask_i,
	input logic [`NUM_WARP-1:0] runMask_i,
	input logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] exitedLanes_i,
	output ctaFrontEndPkg::issueT issue_o
);
	import ctaFrontEndPkg::*;

	logic [`NUM_WARP_LOG-1:0] lastWarp; // round-robin pointer
	logic [`NUM_WARP_LOG-1:0] cand;
	logic [`NUM_WARP_LOG-1:0] pick;
	logic found;
	issueT issueNext;

	// search starts right after the last issued warp and ends on it
	always_comb begin
		pick = lastWarp;
		found = 1'b0;
		cand = lastWarp;
		for (int i = 1; i <= `NUM_WARP; i++) begin
			cand = lastWarp + i[`NUM_WARP_LOG-1:0];
			if (!found && runMask_i[cand]) begin
				pick = cand;
				found = 1'b1;
			end
		end
	end

	always_comb begin
		issueNext.valid = found && !stall_i;
		issueNext.warp = pick;
		issueNext.mask = simdEnMask_i & ~exitedLanes_i[pick]; // drop exited lanes
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			lastWarp <= '1; // so warp 0 goes first
			issue_o.valid <= 1'b0;
		end else begin
			issue_o <= issueNext;
			if (issueNext.valid) begin
				lastWarp <= pick;
			end
		end
	end
endmodule

// File: source/threadController.sv
// exit requests name lanes of one warp; a request to a warp that is not running is still recorded
`timescale 1ns/1ps
`include "ctaFrontEnd_params.svh"

module threadController (
	input logic clk,
	input logic reset_i,
	input logic stall_i,
	input logic [`SIZE_CORE-1:0] simdEnMask_i,
	input ctaFrontEndPkg::exitReqT exitReq_i,
	output logic [`NUM_WARP-1:0][`SIZE_CORE-1:0] exitedLanes_o,
	output logic ctaExit_o,
	output logic [`NUM_WARP_LOG-1:0] exitWarp_o
);

	logic [`SIZE_CORE-1:0] merged;
	logic finished;

	// record of the addressed warp with the new lanes folded in
	assign merged = exitedLanes_o[exitReq_i.warp] | exitReq_i.mask;

	// the whole CTA is gone once every enabled lane has exited
	assign finished = exitReq_i.valid && ((merged & simdEnMask_i) == simdEnMask_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			exitedLanes_o <= '0;
			ctaExit_o <= 1'b0;
		end else if (!stall_i) begin
			// a pending pulse is held through a stall so it is not lost
			ctaExit_o <= finished;
			if (exitReq_i.valid) begin
				if (finished) begin
					exitedLanes_o[exitReq_i.warp] <= '0; // slot gets a fresh CTA
				end else begin
					exitedLanes_o[exitReq_i.warp] <= merged;
				end
			end
		end
	end

	// warp index travels with the exit pulse
	always_ff @(posedge clk) begin
		if (!stall_i && exitReq_i.valid) begin
			exitWarp_o <= exitReq_i.warp;
		end
	end
endmodule

// File: source/ctaController.sv
// cfg_i must be stable from reset on; a ctaExit arriving before the fill phase ends is not served
`timescale 1ns/1ps
`include "ctaFrontEnd_params.svh"

module ctaController (
	input logic clk,
	input logic reset_i,
	input logic stall_i,
	input ctaFrontEndPkg::gridCfgT cfg_i,
	input logic ctaExit_i,
	input logic [`NUM_WARP_LOG-1:0] exitWarp_i,
	output logic [`NUM_WARP-1:0] runMask_o,
	output ctaFrontEndPkg::dispatchT dispatch_o,
	output logic kernelDone_o,
	output logic kernelStall_o
);
	import ctaFrontEndPkg::*;

	ctaStateT state;
	ctaStateT stateNext;
	ctaIdT nextId; // id handed out by the next dispatch
	ctaIdT nextIdNext;
	logic [`SIZE_CTA_CNT-1:0] dispCnt;
	logic [`SIZE_CTA_CNT-1:0] dispCntNext;
	logic [`SIZE_CTA_CNT-1:0] totalCta;
	logic [`NUM_WARP_LOG-1:0] fillSlot;
	logic [`NUM_WARP_LOG-1:0] fillSlotNext;
	logic [`NUM_WARP-1:0] runMaskNext;
	dispatchT dispatchNext;
	logic ctaLeft;
	logic lastCta;

	// step to the following CTA, x fastest then y then z
	function automatic ctaIdT incCtaId(input ctaIdT id, input gridCfgT cfg);
		ctaIdT res;
		res = id;
		if (id.x != cfg.nctaX - 1'b1) begin
			res.x = id.x + 1'b1;
		end else begin
			res.x = '0;
			if (id.y != cfg.nctaY - 1'b1) begin
				res.y = id.y + 1'b1;
			end else begin
				res.y = '0;
				// z wraps only past the last CTA, and that id is never used
				res.z = (id.z != cfg.nctaZ - 1'b1) ? id.z + 1'b1 : '0;
			end
		end
		return res;
	endfunction

	assign totalCta = (`SIZE_CTA_CNT)'(cfg_i.nctaX) * (`SIZE_CTA_CNT)'(cfg_i.nctaY)
		* (`SIZE_CTA_CNT)'(cfg_i.nctaZ);
	assign ctaLeft = (dispCnt != totalCta);
	assign lastCta = (dispCnt + 1'b1 == totalCta); // this dispatch takes the final CTA

	always_comb begin
		stateNext = state;
		nextIdNext = nextId;
		dispCntNext = dispCnt;
		fillSlotNext = fillSlot;
		runMaskNext = runMask_o;
		dispatchNext.valid = 1'b0;
		dispatchNext.warp = fillSlot;
		dispatchNext.ctaId = nextId;
		if (!stall_i) begin
			case (state)
				FILL: begin
					// one slot per cycle, in slot order
					if (ctaLeft) begin
						dispatchNext.valid = 1'b1;
						runMaskNext[fillSlot] = 1'b1;
						nextIdNext = incCtaId(nextId, cfg_i);
						dispCntNext = dispCnt + 1'b1;
					end
					if (!ctaLeft || lastCta || fillSlot == cfg_i.nctaSM) begin
						stateNext = RUN;
					end else begin
						fillSlotNext = fillSlot + 1'b1;
					end
				end
				RUN: begin
					if (ctaExit_i) begin
						dispatchNext.warp = exitWarp_i; // refill the slot that just finished
						if (ctaLeft) begin
							dispatchNext.valid = 1'b1;
							nextIdNext = incCtaId(nextId, cfg_i);
							dispCntNext = dispCnt + 1'b1;
						end else begin
							runMaskNext[exitWarp_i] = 1'b0; // nothing left, retire slot
						end
					end
					if (!ctaLeft && runMask_o == '0) begin
						stateNext = DONE;
					end
				end
				default: begin
					stateNext = DONE; // kernel finished, wait for reset
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= FILL;
			nextId <= '0;
			dispCnt <= '0;
			fillSlot <= '0;
			runMask_o <= '0;
			dispatch_o.valid <= 1'b0;
		end else begin
			state <= stateNext;
			nextId <= nextIdNext;
			dispCnt <= dispCntNext;
			fillSlot <= fillSlotNext;
			runMask_o <= runMaskNext;
			dispatch_o <= dispatchNext;
		end
	end

	assign kernelDone_o = (state == DONE);
	assign kernelStall_o = kernelDone_o || (runMask_o == '0); // no warp able to run
endmodule

// File: source/ctaFrontEndPkg.sv
// structs and the CTA state enum for the front end; needs the params header on the include path
`include "ctaFrontEnd_params.svh"

package ctaFrontEndPkg;

	// one CTA identifier, x counts fastest
	typedef struct packed {
		logic [`SIZE_PREDEFINED-1:0] x;
		logic [`SIZE_PREDEFINED-1:0] y;
		logic [`SIZE_PREDEFINED-1:0] z;
	} ctaIdT;

	// kernel launch configuration, held stable from reset on
	typedef struct packed {
		logic [`SIZE_PREDEFINED-1:0] nctaX;
		logic [`SIZE_PREDEFINED-1:0] nctaY;
		logic [`SIZE_PREDEFINED-1:0] nctaZ;
		logic [`NUM_WARP_LOG-1:0] nctaSM; // slots in use minus one
		logic [`SIZE_CORE-1:0] simdEnMask;
	} gridCfgT;

	// lanes of one warp that executed exit
	typedef struct packed {
		logic valid;
		logic [`NUM_WARP_LOG-1:0] warp;
		logic [`SIZE_CORE-1:0] mask;
	} exitReqT;

	typedef struct packed {
		logic valid;
		logic [`NUM_WARP_LOG-1:0] warp;
		logic [`SIZE_CORE-1:0] mask; // lanes still alive
	} issueT;

	// new CTA bound to a warp slot
	typedef struct packed {
		logic valid;
		logic [`NUM_WARP_LOG-1:0] warp;
		ctaIdT ctaId;
	} dispatchT;

	typedef enum logic [1:0] {
		FILL,
		RUN,
		DONE
	} ctaStateT;

endpackage

// File: source/ctaFrontEnd_params.svh
// compile-time sizes only; NUM_WARP_LOG must equal log2(NUM_WARP) and the CTA count may not exceed 24 bits
`ifndef CTA_FRONT_END_PARAMS_SVH
`define CTA_FRONT_END_PARAMS_SVH

// warp slots in the SM and the width of a slot index
`define NUM_WARP 4
`define NUM_WARP_LOG 2

// lanes per warp
`define SIZE_CORE 8

// width of one CTA-id coordinate (x, y or z)
`define SIZE_PREDEFINED 8

// linear CTA count covers the whole x*y*z grid
`define SIZE_CTA_CNT (3*`SIZE_PREDEFINED)

`endif
